// File: rtl/fillPkg.sv
package fillPkg;

    // external memory controller port
    localparam int EXT_ADDR_W = 30;
    localparam int SRAM_ADDR_W = 10;
    localparam int PROGRESS_W = 10;

    // words per cache line
    localparam int LINE_WORDS = 16;

    // progress value of the last word of a line
    localparam logic [PROGRESS_W-1:0] LAST_PROGRESS = PROGRESS_W'(LINE_WORDS - 1);

    // miss queue per cache
    localparam int MISS_DEPTH = 2;
    localparam int MISS_PTR_W = (MISS_DEPTH > 1) ? $clog2(MISS_DEPTH) : 1;
    localparam int MISS_CNT_W = $clog2(MISS_DEPTH + 1);

    // cache id seen by the controller
    typedef enum logic {
        CACHE_DATA  = 1'b0,
        CACHE_INSTR = 1'b1
    } cacheId_t;

endpackage

// File: rtl/fillRequester.sv
`timescale 1ns/1ps

module fillRequester import fillPkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   missValid,
    input  logic                   missWrite,
    input  logic [EXT_ADDR_W-1:0]  missExtAddr,
    input  logic [SRAM_ADDR_W-1:0] missSramAddr,
    output logic                   missFull,

    output logic                   req,
    output logic                   write,
    output logic [EXT_ADDR_W-1:0]  extAddr,
    output logic [SRAM_ADDR_W-1:0] sramAddr,
    input  logic                   grant,
    input  logic                   done,

    output logic                   fillDone
);

    // miss entries
    logic [EXT_ADDR_W-1:0]  extAddrQ [MISS_DEPTH];
    logic [SRAM_ADDR_W-1:0] sramAddrQ [MISS_DEPTH];
    logic [MISS_DEPTH-1:0]  writeQ;

    logic [MISS_PTR_W-1:0]  headPtr;
    logic [MISS_PTR_W-1:0]  tailPtr;
    logic [MISS_CNT_W-1:0]  count;

    // head entry already handed to the controller
    logic                   granted;

    logic                   push;
    logic                   pop;

    function automatic logic [MISS_PTR_W-1:0] nextPtr(input logic [MISS_PTR_W-1:0] ptr);
        if (ptr == MISS_PTR_W'(MISS_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign missFull = (count == MISS_CNT_W'(MISS_DEPTH));

    // strobe while full is dropped
    assign push = missValid && !missFull;
    assign pop = done && granted;

    assign req = (count != '0) && !granted;
    assign write = writeQ[headPtr];
    assign extAddr = extAddrQ[headPtr];
    assign sramAddr = sramAddrQ[headPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            extAddrQ[tailPtr] <= missExtAddr;
            sramAddrQ[tailPtr] <= missSramAddr;
            writeQ[tailPtr] <= missWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
            granted <= 1'b0;
            fillDone <= 1'b0;
        end
        else begin
            if (push) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (pop) begin
                headPtr <= nextPtr(headPtr);
            end

            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase

            // req drops from grant until done
            if (pop) begin
                granted <= 1'b0;
            end
            else if (grant) begin
                granted <= 1'b1;
            end

            fillDone <= pop;
        end
    end

endmodule

// File: rtl/fillArbiter.sv
`timescale 1ns/1ps

module fillArbiter import fillPkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    // instruction side
    input  logic                   icReq,
    input  logic [EXT_ADDR_W-1:0]  icExtAddr,
    input  logic [SRAM_ADDR_W-1:0] icSramAddr,
    output logic                   icGrant,
    output logic                   icDone,

    // data side
    input  logic                   dcReq,
    input  logic                   dcWrite,
    input  logic [EXT_ADDR_W-1:0]  dcExtAddr,
    input  logic [SRAM_ADDR_W-1:0] dcSramAddr,
    output logic                   dcGrant,
    output logic                   dcDone,

    // controller port
    output logic                   mcCe,
    output logic                   mcWe,
    output cacheId_t               mcCacheId,
    output logic [SRAM_ADDR_W-1:0] mcSramAddr,
    output logic [EXT_ADDR_W-1:0]  mcExtAddr,
    input  logic                   mcBusy,
    input  logic [PROGRESS_W-1:0]  mcProgress
);

    logic     inFlight;
    cacheId_t owner;
    logic     portFree;
    logic     fillEnd;

    // no new fill while one is tracked or the controller is busy
    assign portFree = !inFlight && !mcBusy;

    // fetch wins a tie
    assign icGrant = portFree && icReq;
    assign dcGrant = portFree && dcReq && !icReq;

    assign mcCe = icGrant || dcGrant;

    // fetch side never writes
    assign mcWe = dcGrant && dcWrite;

    always_comb begin
        if (icGrant) begin
            mcSramAddr = icSramAddr;
            mcExtAddr = icExtAddr;
        end
        else begin
            mcSramAddr = dcSramAddr;
            mcExtAddr = dcExtAddr;
        end
    end

    always_comb begin
        if (inFlight) begin
            mcCacheId = owner;
        end
        else if (icGrant) begin
            mcCacheId = CACHE_INSTR;
        end
        else begin
            mcCacheId = CACHE_DATA;
        end
    end

    // last word of the line seen while busy
    assign fillEnd = inFlight && mcBusy && (mcProgress == LAST_PROGRESS);

    assign icDone = fillEnd && (owner == CACHE_INSTR);
    assign dcDone = fillEnd && (owner == CACHE_DATA);

    always_ff @(posedge clk) begin
        if (rst) begin
            inFlight <= 1'b0;
            owner <= CACHE_DATA;
        end
        else if (mcCe) begin
            inFlight <= 1'b1;
            owner <= icGrant ? CACHE_INSTR : CACHE_DATA;
        end
        else if (fillEnd) begin
            inFlight <= 1'b0;
        end
    end

endmodule

// File: rtl/cacheFillPort.sv
`timescale 1ns/1ps

module cacheFillPort import fillPkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    // instruction cache misses
    input  logic                   icMissValid,
    input  logic [EXT_ADDR_W-1:0]  icMissExtAddr,
    input  logic [SRAM_ADDR_W-1:0] icMissSramAddr,
    output logic                   icMissFull,
    output logic                   icFillDone,

    // data cache misses
    input  logic                   dcMissValid,
    input  logic                   dcMissWrite,
    input  logic [EXT_ADDR_W-1:0]  dcMissExtAddr,
    input  logic [SRAM_ADDR_W-1:0] dcMissSramAddr,
    output logic                   dcMissFull,
    output logic                   dcFillDone,

    // memory controller
    output logic                   mcCe,
    output logic                   mcWe,
    output cacheId_t               mcCacheId,
    output logic [SRAM_ADDR_W-1:0] mcSramAddr,
    output logic [EXT_ADDR_W-1:0]  mcExtAddr,
    input  logic                   mcBusy,
    input  logic [PROGRESS_W-1:0]  mcProgress
);

    logic                   icReq;
    logic [EXT_ADDR_W-1:0]  icExtAddr;
    logic [SRAM_ADDR_W-1:0] icSramAddr;
    logic                   icGrant;
    logic                   icDone;

    logic                   dcReq;
    logic                   dcWrite;
    logic [EXT_ADDR_W-1:0]  dcExtAddr;
    logic [SRAM_ADDR_W-1:0] dcSramAddr;
    logic                   dcGrant;
    logic                   dcDone;

    // instruction fills are read only
    fillRequester icRequester (
        .clk(clk),
        .rst(rst),
        .missValid(icMissValid),
        .missWrite(1'b0),
        .missExtAddr(icMissExtAddr),
        .missSramAddr(icMissSramAddr),
        .missFull(icMissFull),
        .req(icReq),
        .write(),
        .extAddr(icExtAddr),
        .sramAddr(icSramAddr),
        .grant(icGrant),
        .done(icDone),
        .fillDone(icFillDone)
    );

    fillRequester dcRequester (
        .clk(clk),
        .rst(rst),
        .missValid(dcMissValid),
        .missWrite(dcMissWrite),
        .missExtAddr(dcMissExtAddr),
        .missSramAddr(dcMissSramAddr),
        .missFull(dcMissFull),
        .req(dcReq),
        .write(dcWrite),
        .extAddr(dcExtAddr),
        .sramAddr(dcSramAddr),
        .grant(dcGrant),
        .done(dcDone),
        .fillDone(dcFillDone)
    );

    fillArbiter fillArbiter (
        .clk(clk),
        .rst(rst),
        .icReq(icReq),
        .icExtAddr(icExtAddr),
        .icSramAddr(icSramAddr),
        .icGrant(icGrant),
        .icDone(icDone),
        .dcReq(dcReq),
        .dcWrite(dcWrite),
        .dcExtAddr(dcExtAddr),
        .dcSramAddr(dcSramAddr),
        .dcGrant(dcGrant),
        .dcDone(dcDone),
        .mcCe(mcCe),
        .mcWe(mcWe),
        .mcCacheId(mcCacheId),
        .mcSramAddr(mcSramAddr),
        .mcExtAddr(mcExtAddr),
        .mcBusy(mcBusy),
        .mcProgress(mcProgress)
    );

endmodule

// File: testbench/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // released just after the fourth rising edge
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: testbench/cacheFillPort_checker.sv
`timescale 1ns/1ps

module cacheFillPort_checker import fillPkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     mcCe,
    input logic     mcWe,
    input logic     mcBusy,
    input cacheId_t mcCacheId
);

    // a grant lasts a single cycle
    ceOnePulse: assert property (@(posedge clk) disable iff (rst) mcCe |=> !mcCe)
        else $error("mcCe high for more than one cycle");

    ceNotBusy: assert property (@(posedge clk) disable iff (rst) mcCe |-> !mcBusy)
        else $error("mcCe raised while mcBusy is high");

    // only data fills may write
    weOnlyData: assert property (
        @(posedge clk) disable iff (rst) mcWe |-> (mcCacheId == CACHE_DATA))
        else $error("mcWe high without CACHE_DATA");

endmodule

// File: testbench/cacheFillPort_tb.sv
`timescale 1ns/1ps

module cacheFillPort_tb import fillPkg::*; ();

    localparam int RANDOM_ROUNDS = 24;
    localparam int MAX_MISSES = 8 + 2 * RANDOM_ROUNDS;
    // line plus idle busy, handshake and gap cycles
    localparam int CYCLES_PER_MISS = LINE_WORDS + 16;
    localparam real TIMEOUT_NS = 20.0 * (MAX_MISSES * CYCLES_PER_MISS + 20);

    typedef struct packed {
        logic                   write;
        logic [EXT_ADDR_W-1:0]  ext;
        logic [SRAM_ADDR_W-1:0] sram;
    } missEntry_t;

    logic                   clk;
    logic                   rst;
    logic                   icMissValid;
    logic [EXT_ADDR_W-1:0]  icMissExtAddr;
    logic [SRAM_ADDR_W-1:0] icMissSramAddr;
    logic                   icMissFull;
    logic                   icFillDone;
    logic                   dcMissValid;
    logic                   dcMissWrite;
    logic [EXT_ADDR_W-1:0]  dcMissExtAddr;
    logic [SRAM_ADDR_W-1:0] dcMissSramAddr;
    logic                   dcMissFull;
    logic                   dcFillDone;
    logic                   mcCe;
    logic                   mcWe;
    cacheId_t               mcCacheId;
    logic [SRAM_ADDR_W-1:0] mcSramAddr;
    logic [EXT_ADDR_W-1:0]  mcExtAddr;
    logic                   mcBusy = 1'b0;
    logic [PROGRESS_W-1:0]  mcProgress = '0;

    // misses accepted by the DUT and not yet filled
    missEntry_t icQ[$];
    missEntry_t dcQ[$];
    logic       pendingValid = 1'b0;
    cacheId_t   pendingId = CACHE_DATA;

    logic [31:0] lfsrState = 32'h183c93b4;
    int errors = 0;
    int errorsAtStart = 0;
    int passed = 0;
    int failed = 0;
    int issued = 0;
    int grantCount = 0;
    int doneCount = 0;

    tbClock clockGen (.clk(clk), .rst(rst));

    cacheFillPort cacheFillPort_inst (.*);

    bind fillArbiter cacheFillPort_checker arbiterChecker (
        .clk(clk), .rst(rst), .mcCe(mcCe), .mcWe(mcWe), .mcBusy(mcBusy), .mcCacheId(mcCacheId)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // oldest instruction miss is granted before any data miss
    function automatic missEntry_t predictFill(output cacheId_t id);
        missEntry_t e;
        if (icQ.size() != 0) begin
            id = CACHE_INSTR;
            e = icQ[0];
            e.write = 1'b0;
            return e;
        end
        id = CACHE_DATA;
        return dcQ[0];
    endfunction

    task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] want);
        $display("FAILED at %0t: %s got %h expected %h", $time, name, got, want);
        errors++;
    endtask

    task automatic problem(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    // enters and leaves 1 ns after a rising edge
    task automatic issueMisses(input logic doIc, input logic doDc);
        missEntry_t ic;
        missEntry_t dc;
        ic.write = 1'b0;
        ic.ext = EXT_ADDR_W'(randBits(EXT_ADDR_W));
        ic.sram = SRAM_ADDR_W'(randBits(SRAM_ADDR_W));
        dc.write = 1'(randBits(1));
        dc.ext = EXT_ADDR_W'(randBits(EXT_ADDR_W));
        dc.sram = SRAM_ADDR_W'(randBits(SRAM_ADDR_W));
        while ((doIc && icMissFull) || (doDc && dcMissFull)) begin
            @(posedge clk);
            #1;
        end
        icMissValid = doIc;
        icMissExtAddr = ic.ext;
        icMissSramAddr = ic.sram;
        dcMissValid = doDc;
        dcMissWrite = dc.write;
        dcMissExtAddr = dc.ext;
        dcMissSramAddr = dc.sram;
        @(posedge clk);
        if (doIc)
            icQ.push_back(ic);
        if (doDc)
            dcQ.push_back(dc);
        issued += int'(doIc) + int'(doDc);
        #1;
        icMissValid = 1'b0;
        dcMissValid = 1'b0;
    endtask

    task automatic drain();
        @(posedge clk);
        while (icQ.size() != 0 || dcQ.size() != 0 || mcBusy)
            @(posedge clk);
        #1;
    endtask

    task automatic finishTest(input string name);
        drain();
        if (grantCount != issued)
            mismatch("grant count", grantCount, issued);
        if (doneCount != issued)
            mismatch("fill-done count", doneCount, issued);
        if (errors == errorsAtStart) begin
            passed++;
            $display("test %s: ok", name);
        end
        else begin
            failed++;
            $display("test %s: %0d errors", name, errors - errorsAtStart);
        end
        errorsAtStart = errors;
        grantCount = 0;
        doneCount = 0;
        issued = 0;
    endtask

    // memory controller model sends one word per cycle and then idles busy for a few cycles
    always begin : controllerModel
        int idle;
        @(negedge clk);
        if (mcCe && !rst) begin
            idle = int'(randBits(2));
            @(posedge clk);
            #1;
            mcBusy = 1'b1;
            mcProgress = '0;
            for (int w = 1; w < LINE_WORDS; w++) begin
                @(posedge clk);
                #1;
                mcProgress = PROGRESS_W'(w);
            end
            repeat (idle + 1) @(posedge clk);
            #1;
            mcBusy = 1'b0;
            mcProgress = '0;
        end
    end

    // outputs settle by the falling edge
    always @(negedge clk) begin : compare
        missEntry_t expected;
        cacheId_t   expId;
        if (!rst && (icFillDone || dcFillDone)) begin
            doneCount++;
            if (!pendingValid)
                problem("fill-done pulse with no fill in flight");
            else begin
                if (icFillDone !== (pendingId == CACHE_INSTR))
                    mismatch("icFillDone", icFillDone, pendingId == CACHE_INSTR);
                if (dcFillDone !== (pendingId == CACHE_DATA))
                    mismatch("dcFillDone", dcFillDone, pendingId == CACHE_DATA);
                if (pendingId == CACHE_INSTR)
                    void'(icQ.pop_front());
                else
                    void'(dcQ.pop_front());
            end
            pendingValid = 1'b0;
        end
        if (!rst && mcCe) begin
            grantCount++;
            if (mcBusy)
                problem("mcCe raised while mcBusy is high");
            if (pendingValid || (icQ.size() == 0 && dcQ.size() == 0))
                problem("mcCe with no waiting miss or during a fill");
            else begin
                expected = predictFill(expId);
                if (mcCacheId !== expId)
                    mismatch("mcCacheId", mcCacheId, expId);
                if (mcWe !== expected.write)
                    mismatch("mcWe", mcWe, expected.write);
                if (mcExtAddr !== expected.ext)
                    mismatch("mcExtAddr", mcExtAddr, expected.ext);
                if (mcSramAddr !== expected.sram)
                    mismatch("mcSramAddr", mcSramAddr, expected.sram);
                pendingValid = 1'b1;
                pendingId = expId;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: fills still open at %0t", $time);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [1:0] pick;
        icMissValid = 1'b0;
        icMissExtAddr = '0;
        icMissSramAddr = '0;
        dcMissValid = 1'b0;
        dcMissWrite = 1'b0;
        dcMissExtAddr = '0;
        dcMissSramAddr = '0;
        @(posedge clk);
        while (rst)
            @(posedge clk);
        #1;

        if (mcCe !== 1'b0)
            mismatch("mcCe", mcCe, 0);
        if (mcWe !== 1'b0)
            mismatch("mcWe", mcWe, 0);
        if (mcCacheId !== CACHE_DATA)
            mismatch("mcCacheId", mcCacheId, CACHE_DATA);
        if (icMissFull !== 1'b0 || dcMissFull !== 1'b0)
            mismatch("icMissFull/dcMissFull", {icMissFull, dcMissFull}, 0);
        if (icFillDone !== 1'b0 || dcFillDone !== 1'b0)
            mismatch("icFillDone/dcFillDone", {icFillDone, dcFillDone}, 0);
        finishTest("reset state");

        issueMisses(1'b1, 1'b0);
        drain();
        issueMisses(1'b0, 1'b1);
        finishTest("single fills");

        issueMisses(1'b1, 1'b1);
        finishTest("tie priority");

        issueMisses(1'b1, 1'b0);
        if (icMissFull !== 1'b0)
            mismatch("icMissFull", icMissFull, 0);
        issueMisses(1'b1, 1'b0);
        if (icMissFull !== 1'b1)
            mismatch("icMissFull", icMissFull, 1);
        issueMisses(1'b0, 1'b1);
        issueMisses(1'b0, 1'b1);
        if (dcMissFull !== 1'b1)
            mismatch("dcMissFull", dcMissFull, 1);
        finishTest("queue order and full flag");

        for (int n = 0; n < RANDOM_ROUNDS; n++) begin
            pick = 2'(randBits(2));
            issueMisses(pick != 2'd2, pick[1]);
            repeat (int'(randBits(3))) begin
                @(posedge clk);
                #1;
            end
        end
        finishTest("busy hold-off and random traffic");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 passed + failed, passed, failed, errors);
        if (errors == 0 && failed == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: filelist.f
rtl/fillPkg.sv
rtl/fillRequester.sv
rtl/fillArbiter.sv
rtl/cacheFillPort.sv
testbench/tbClock.sv
testbench/cacheFillPort_checker.sv
testbench/cacheFillPort_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cacheFillPort_tb -f filelist.f -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation stopped without a result"
    exit 1
fi
echo "simulation passed"
